/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int xlen_w = 32;
  localparam int imem_depth = 1024; // Instruction words
  localparam int imem_idx_w = $clog2(imem_depth);

  localparam logic [xlen_w-1:0] reset_pc = 32'h0000_0000;
  localparam logic [xlen_w-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

  typedef struct packed {
    logic trap;
    logic mret;
    logic [xlen_w-1:0] mtvec;
    logic [xlen_w-1:0] mepc;
  } csr_redirect_type;

  typedef struct packed {
    logic [xlen_w-1:0] pc;
    logic [xlen_w-1:0] npc;
    logic branch;
    logic jump_uncond;
    logic return_pop;
  } decode_info_type;

  typedef struct packed {
    logic [xlen_w-1:0] pc;
    logic [xlen_w-1:0] npc;
    logic [xlen_w-1:0] address; // Resolved target
    logic jump;                 // Transfer actually taken
    logic branch;
    logic jump_uncond;
    logic return_push;
  } execute_info_type;

  typedef struct packed {
    logic [xlen_w-1:0] pc;
    logic [xlen_w-1:0] instr;
    logic taken;
    logic valid;
  } fetch_out_type;

  typedef struct packed {
    logic valid;
    logic spec;
    logic [xlen_w-1:0] addr;
  } imem_req_type;

  typedef struct packed {
    logic ready;
    logic [xlen_w-1:0] rdata;
  } imem_rsp_type;

endpackage

`default_nettype wire

/* rtl/predict_pkg.sv */
`default_nettype none

package predict_pkg;

  localparam int bht_depth = 64;
  localparam int btb_depth = 32;
  localparam int ras_depth = 4;

  localparam int bht_idx_w = $clog2(bht_depth);
  localparam int btb_idx_w = $clog2(btb_depth);
  localparam int ras_ptr_w = $clog2(ras_depth);
  localparam int btb_tag_w = fetch_pkg::xlen_w - btb_idx_w - 1; // Bit 0 never indexes

  typedef struct packed {
    logic [btb_tag_w-1:0] tag;
    logic [fetch_pkg::xlen_w-1:0] target;
  } btb_entry_type;

  typedef struct packed {
    logic [fetch_pkg::xlen_w-1:0] get_pc;
    logic get_branch;
    logic get_return;
    logic get_uncond;
    logic [fetch_pkg::xlen_w-1:0] upd_pc;
    logic [fetch_pkg::xlen_w-1:0] upd_npc;
    logic [fetch_pkg::xlen_w-1:0] upd_addr;
    logic upd_branch;
    logic upd_return;
    logic upd_uncond;
    logic upd_jump;
    logic stall;
    logic clear;
  } bp_in_type;

  typedef struct packed {
    logic pred_branch;
    logic pred_jump;
    logic pred_return;
    logic pred_uncond;
    logic [fetch_pkg::xlen_w-1:0] pred_baddr;
    logic [fetch_pkg::xlen_w-1:0] pred_raddr;
  } bp_out_type;

endpackage

`default_nettype wire

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
  input  logic clock,
  input  logic reset,
  input  predict_pkg::bp_in_type bp_in,
  output predict_pkg::bp_out_type bp_out
);

  import fetch_pkg::*;
  import predict_pkg::*;

  logic [1:0] bht [bht_depth];
  logic [btb_depth-1:0] btb_valid;
  btb_entry_type btb [btb_depth];
  logic [xlen_w-1:0] ras [ras_depth];
  logic [ras_ptr_w-1:0] ras_ptr; // Next free slot
  logic [ras_ptr_w:0] ras_count;

  logic [bht_idx_w-1:0] get_bht_idx;
  logic [bht_idx_w-1:0] upd_bht_idx;
  logic [btb_idx_w-1:0] get_btb_idx;
  logic [btb_idx_w-1:0] upd_btb_idx;
  logic [btb_tag_w-1:0] get_tag;
  logic [btb_tag_w-1:0] upd_tag;
  logic btb_hit;
  logic btb_write;
  logic [1:0] upd_count;
  logic [ras_ptr_w-1:0] ras_top;
  logic ras_pop;
  logic ras_push;

  assign get_bht_idx = bp_in.get_pc[bht_idx_w:1];
  assign upd_bht_idx = bp_in.upd_pc[bht_idx_w:1];
  assign get_btb_idx = bp_in.get_pc[btb_idx_w:1];
  assign upd_btb_idx = bp_in.upd_pc[btb_idx_w:1];
  assign get_tag = bp_in.get_pc[xlen_w-1:btb_idx_w+1];
  assign upd_tag = bp_in.upd_pc[xlen_w-1:btb_idx_w+1];

  assign btb_hit = btb_valid[get_btb_idx] && (btb[get_btb_idx].tag == get_tag);
  assign ras_top = ras_ptr - 1'b1;

  always_comb begin
    bp_out.pred_branch = bp_in.get_branch && btb_hit;
    bp_out.pred_jump = bht[get_bht_idx][1]; // Counter at 2 or 3
    bp_out.pred_uncond = bp_in.get_uncond && btb_hit;
    bp_out.pred_baddr = btb[get_btb_idx].target;
    bp_out.pred_return = bp_in.get_return && (ras_count != '0);
    bp_out.pred_raddr = ras[ras_top];
  end

  assign ras_pop = bp_out.pred_return && !bp_in.stall;
  assign ras_push = bp_in.upd_return && !bp_in.stall;
  assign btb_write = !bp_in.stall && ((bp_in.upd_branch && bp_in.upd_jump) || bp_in.upd_uncond);

  // Saturating 2-bit counter step
  always_comb begin
    upd_count = bht[upd_bht_idx];
    if (bp_in.upd_jump && upd_count != 2'b11) begin
      upd_count = upd_count + 2'b01;
    end else if (!bp_in.upd_jump && upd_count != 2'b00) begin
      upd_count = upd_count - 2'b01;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < bht_depth; i++) begin
        bht[i] <= 2'b00;
      end
      btb_valid <= '0;
    end else if (!bp_in.stall) begin
      if (bp_in.upd_branch) begin
        bht[upd_bht_idx] <= upd_count;
      end
      if (btb_write) begin
        btb_valid[upd_btb_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (btb_write) begin
      btb[upd_btb_idx] <= '{tag: upd_tag, target: bp_in.upd_addr};
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ras_ptr <= '0;
      ras_count <= '0;
    end else if (bp_in.clear) begin
      ras_ptr <= '0;
      ras_count <= '0;
    end else if (ras_push && !ras_pop) begin
      ras_ptr <= ras_ptr + 1'b1; // Wraps over the oldest entry
      if (ras_count != (ras_ptr_w + 1)'(ras_depth)) begin
        ras_count <= ras_count + 1'b1;
      end
    end else if (ras_pop && !ras_push) begin
      ras_ptr <= ras_top;
      ras_count <= ras_count - 1'b1;
    end
  end

  // Pop and push together replace the top entry
  always_ff @(posedge clock) begin
    if (ras_push) begin
      ras[ras_pop ? ras_top : ras_ptr] <= bp_in.upd_npc;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  logic clock,
  input  logic load_en,
  input  logic [fetch_pkg::imem_idx_w-1:0] load_addr,
  input  logic [fetch_pkg::xlen_w-1:0] load_data,
  input  fetch_pkg::imem_req_type imem_req,
  output fetch_pkg::imem_rsp_type imem_rsp
);

  import fetch_pkg::*;

  logic [xlen_w-1:0] mem [imem_depth];

  logic [imem_idx_w-1:0] word_lo;
  logic [imem_idx_w-1:0] word_hi;
  logic start;
  logic [xlen_w-1:0] data_lo;
  logic [xlen_w-1:0] data_hi;
  logic upper_half;
  logic ready_q;

  assign word_lo = imem_req.addr[imem_idx_w+1:2];
  assign word_hi = word_lo + 1'b1; // Wraps at the top of memory

  // A redirect always starts a read and replaces the word in flight
  assign start = imem_req.valid || imem_req.spec;

  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      data_lo <= mem[word_lo];
      data_hi <= mem[word_hi];
      upper_half <= imem_req.addr[1];
    end
  end

  // Ready in the cycle after a read
  always_ff @(posedge clock) begin
    ready_q <= start;
  end

  always_comb begin
    imem_rsp.ready = ready_q;
    if (upper_half) begin
      imem_rsp.rdata = {data_hi[15:0], data_lo[31:16]}; // Straddles two words
    end else begin
      imem_rsp.rdata = data_lo;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic clock,
  input  logic reset,
  input  fetch_pkg::csr_redirect_type csr,
  input  fetch_pkg::decode_info_type decode,
  input  fetch_pkg::execute_info_type execute,
  input  logic stall,
  input  logic clear,
  input  predict_pkg::bp_out_type bp_out,
  output predict_pkg::bp_in_type bp_in,
  input  fetch_pkg::imem_rsp_type imem_rsp,
  output fetch_pkg::imem_req_type imem_req,
  output fetch_pkg::fetch_out_type fetch
);

  import fetch_pkg::*;

  logic [xlen_w-1:0] pc_q; // Address of the word arriving now
  logic taken_q;
  fetch_out_type fetch_q;

  logic [xlen_w-1:0] pc_next;
  logic taken_next;
  logic redirect;
  logic mis_take;
  logic mis_skip;
  logic mis_addr;
  logic [xlen_w-1:0] step;

  always_comb begin
    bp_in.get_pc = decode.pc;
    bp_in.get_branch = decode.branch;
    bp_in.get_return = decode.return_pop;
    bp_in.get_uncond = decode.jump_uncond;
    bp_in.upd_pc = execute.pc;
    bp_in.upd_npc = execute.npc;
    bp_in.upd_addr = execute.address;
    bp_in.upd_branch = execute.branch;
    bp_in.upd_return = execute.return_push;
    bp_in.upd_uncond = execute.jump_uncond;
    bp_in.upd_jump = execute.jump;
    bp_in.stall = stall;
    bp_in.clear = clear;
  end

  assign mis_take = execute.jump && !fetch_q.taken;
  assign mis_skip = !execute.jump && fetch_q.taken;
  assign mis_addr = execute.jump && fetch_q.taken && (execute.address != fetch_q.pc);

  assign step = (imem_rsp.rdata[1:0] == 2'b11) ? xlen_w'(4) : xlen_w'(2);

  always_comb begin
    pc_next = pc_q;
    taken_next = taken_q;
    redirect = 1'b1;
    if (csr.trap) begin
      pc_next = csr.mtvec;
      taken_next = 1'b0;
    end else if (csr.mret) begin
      pc_next = csr.mepc;
      taken_next = 1'b0;
    end else if (mis_take || mis_addr) begin
      pc_next = execute.address;
      taken_next = 1'b0;
    end else if (mis_skip) begin
      pc_next = decode.npc; // Fall through after a wrong taken guess
      taken_next = 1'b0;
    end else if (bp_out.pred_return) begin
      pc_next = bp_out.pred_raddr;
      taken_next = 1'b1;
    end else if (bp_out.pred_uncond) begin
      pc_next = bp_out.pred_baddr;
      taken_next = 1'b1;
    end else if (bp_out.pred_branch && bp_out.pred_jump) begin
      pc_next = bp_out.pred_baddr;
      taken_next = 1'b1;
    end else begin
      redirect = 1'b0;
      if (imem_rsp.ready && !stall) begin
        pc_next = pc_q + step;
        taken_next = 1'b0;
      end
    end
  end

  always_comb begin
    imem_req.valid = redirect || !stall;
    imem_req.spec = redirect;
    imem_req.addr = pc_next;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q <= reset_pc;
      taken_q <= 1'b0;
      fetch_q <= '{pc: reset_pc, instr: nop_instr, taken: 1'b0, valid: 1'b0};
    end else begin
      pc_q <= pc_next;
      taken_q <= taken_next;
      if (!stall) begin
        fetch_q.pc <= pc_q;
        fetch_q.instr <= imem_rsp.ready ? imem_rsp.rdata : nop_instr;
        fetch_q.taken <= taken_q;
        fetch_q.valid <= imem_rsp.ready;
      end
    end
  end

  assign fetch = fetch_q;

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic clock,
  input  logic reset,
  input  fetch_pkg::csr_redirect_type csr,
  input  fetch_pkg::decode_info_type decode,
  input  fetch_pkg::execute_info_type execute,
  input  logic stall,
  input  logic clear,
  input  logic load_en,
  input  logic [9:0] load_addr,
  input  logic [31:0] load_data,
  output fetch_pkg::fetch_out_type fetch
);

  import fetch_pkg::*;
  import predict_pkg::*;

  bp_in_type bp_in;
  bp_out_type bp_out;
  imem_req_type imem_req;
  imem_rsp_type imem_rsp;

  fetch_stage i_fetch_stage (
    .clock(clock),
    .reset(reset),
    .csr(csr),
    .decode(decode),
    .execute(execute),
    .stall(stall),
    .clear(clear),
    .bp_out(bp_out),
    .bp_in(bp_in),
    .imem_rsp(imem_rsp),
    .imem_req(imem_req),
    .fetch(fetch)
  );

  branch_predictor i_branch_predictor (
    .clock(clock),
    .reset(reset),
    .bp_in(bp_in),
    .bp_out(bp_out)
  );

  fetch_buffer i_fetch_buffer (
    .clock(clock),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .imem_req(imem_req),
    .imem_rsp(imem_rsp)
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

  import fetch_pkg::*;

  localparam int seq_cycles = 300;
  localparam int num_steps = imem_depth + seq_cycles + 200;
  localparam int watchdog_ns = num_steps * 20 * 8;

  logic clock;
  logic reset;
  csr_redirect_type csr;
  decode_info_type decode;
  execute_info_type execute;
  logic stall;
  logic clear;
  logic load_en;
  logic [9:0] load_addr;
  logic [31:0] load_data;
  fetch_out_type fetch;

  integer seed = 32'h16de;
  logic [31:0] mem_image [imem_depth];
  logic [15:0] halves [2*imem_depth];

  logic seq_on;
  logic seq_armed;
  logic [31:0] prev_pc;
  logic [31:0] prev_instr;
  logic prev_valid;
  logic exp_on;
  logic [31:0] exp_pc;
  logic exp_taken;
  logic stall_chk;
  logic [31:0] rand_pc;
  int seq_hits;
  int instr_hits;
  int target_hits;
  int stall_hits;

  clock_gen i_clock_gen (.clock(clock), .reset(reset));

  fetch_unit i_dut (
    .clock(clock),
    .reset(reset),
    .csr(csr),
    .decode(decode),
    .execute(execute),
    .stall(stall),
    .clear(clear),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .fetch(fetch)
  );

  function automatic logic [31:0] step_of(input logic [31:0] instr);
    return (instr[1:0] == 2'b11) ? 32'd4 : 32'd2; // Full word or compressed
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] pc);
    logic [9:0] idx;
    logic [31:0] lo;
    logic [31:0] hi;
    idx = pc[11:2];
    lo = mem_image[idx];
    hi = mem_image[idx + 10'd1];
    if (pc[1]) begin
      return {hi[15:0], lo[31:16]};
    end
    return lo;
  endfunction

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("Error: time %0t %s expected %h got %h", $time, name, expected, actual);
    $display("Test failures found");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    prev_pc <= fetch.pc;
    prev_instr <= fetch.instr;
    prev_valid <= fetch.valid;
    seq_armed <= seq_on;
    if (reset && seq_on && seq_armed && prev_valid) seq_hits <= seq_hits + 1;
    if (reset && seq_on && fetch.valid) instr_hits <= instr_hits + 1;
    if (reset && exp_on) target_hits <= target_hits + 1;
    if (reset && stall_chk) stall_hits <= stall_hits + 1;
  end

  seq_pc_a: assert property (@(posedge clock) disable iff (!reset)
    (seq_on && seq_armed && prev_valid) |-> (fetch.pc == prev_pc + step_of(prev_instr)))
    else report_value("fetch.pc", $sampled(prev_pc) + step_of($sampled(prev_instr)),
                      $sampled(fetch.pc));

  seq_instr_a: assert property (@(posedge clock) disable iff (!reset)
    (seq_on && fetch.valid) |-> (fetch.instr == read_word(fetch.pc)))
    else report_value("fetch.instr", read_word($sampled(fetch.pc)), $sampled(fetch.instr));

  target_pc_a: assert property (@(posedge clock) disable iff (!reset)
    exp_on |-> (fetch.pc == exp_pc))
    else report_value("fetch.pc", $sampled(exp_pc), $sampled(fetch.pc));

  target_taken_a: assert property (@(posedge clock) disable iff (!reset)
    exp_on |-> (fetch.taken == exp_taken))
    else report_value("fetch.taken", {31'd0, $sampled(exp_taken)},
                      {31'd0, $sampled(fetch.taken)});

  target_valid_a: assert property (@(posedge clock) disable iff (!reset)
    exp_on |-> fetch.valid)
    else report_value("fetch.valid", 32'd1, {31'd0, $sampled(fetch.valid)});

  stall_pc_a: assert property (@(posedge clock) disable iff (!reset)
    stall_chk |-> (fetch.pc == prev_pc))
    else report_value("fetch.pc", $sampled(prev_pc), $sampled(fetch.pc));

  // Random mix of 16 and 32 bit encodings, packed as halfwords
  task automatic build_program();
    int i;
    logic [31:0] r;
    i = 0;
    while (i < 2 * imem_depth) begin
      r = $random(seed);
      if (r[0] || i == 2 * imem_depth - 1) begin
        halves[i] = {r[15:2], (r[17:16] == 2'b11) ? 2'b01 : r[17:16]};
        i = i + 1;
      end else begin
        halves[i] = {r[15:2], 2'b11};
        halves[i+1] = r[31:16];
        i = i + 2;
      end
    end
    for (int w = 0; w < imem_depth; w++) begin
      mem_image[w] = {halves[2*w+1], halves[2*w]};
    end
  endtask

  task automatic load_program();
    for (int w = 0; w < imem_depth; w++) begin
      @(negedge clock);
      load_en = 1'b1;
      load_addr = w[9:0];
      load_data = mem_image[w];
    end
    @(negedge clock);
    load_en = 1'b0;
  endtask

  // Entered on the falling edge right after the redirect edge
  task automatic check_target(input logic [31:0] pc, input logic taken);
    @(negedge clock);
    exp_pc = pc;
    exp_taken = taken;
    exp_on = 1'b1;
    @(negedge clock);
    exp_on = 1'b0;
  endtask

  task automatic csr_redirect(input logic trap, input logic mret, input logic [31:0] mtvec,
                              input logic [31:0] mepc, input logic [31:0] expected);
    seq_on = 1'b0;
    csr.trap = trap;
    csr.mret = mret;
    csr.mtvec = mtvec;
    csr.mepc = mepc;
    @(negedge clock);
    csr = '0;
    check_target(expected, 1'b0);
  endtask

  task automatic run_sequential(input logic [31:0] start, input int cycles);
    csr_redirect(1'b1, 1'b0, start, 32'd0, start);
    seq_on = 1'b1;
    repeat (cycles) @(negedge clock);
    seq_on = 1'b0;
  endtask

  initial begin
    csr = '0;
    decode = '0;
    execute = '0;
    stall = 1'b0;
    clear = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    seq_on = 1'b0;
    exp_on = 1'b0;
    exp_pc = '0;
    exp_taken = 1'b0;
    stall_chk = 1'b0;
    rand_pc = '0;
    seq_hits = 0;
    instr_hits = 0;
    target_hits = 0;
    stall_hits = 0;
    build_program();
    load_program();
    wait (reset === 1'b1);

    run_sequential(32'h0000_0100, seq_cycles);

    rand_pc = $random(seed) & 32'h0000_0ffe;
    csr_redirect(1'b1, 1'b0, rand_pc, 32'd0, rand_pc);
    csr_redirect(1'b1, 1'b0, 32'h0000_0522, 32'd0, 32'h0000_0522);
    csr_redirect(1'b0, 1'b1, 32'd0, 32'h0000_07a6, 32'h0000_07a6);
    csr_redirect(1'b1, 1'b1, 32'h0000_0310, 32'h0000_0664, 32'h0000_0310); // Trap wins
    run_sequential($random(seed) & 32'h0000_0ffe, 20);

    // Mispredict with the current fetch untaken
    execute.jump = 1'b1;
    execute.address = 32'h0000_0c1a;
    @(negedge clock);
    execute = '0;
    check_target(32'h0000_0c1a, 1'b0);
    run_sequential(32'h0000_0200, 20);

    // Two taken updates push the counter to 2
    execute.pc = 32'h0000_0240;
    execute.npc = 32'h0000_0244;
    execute.address = 32'h0000_0a36;
    execute.branch = 1'b1;
    execute.jump = 1'b1;
    repeat (2) @(negedge clock);
    execute = '0;
    @(negedge clock);
    decode.pc = 32'h0000_0240;
    decode.npc = 32'h0000_0244;
    decode.branch = 1'b1;
    @(negedge clock);
    decode = '0;
    check_target(32'h0000_0a36, 1'b1);
    run_sequential(32'h0000_0400, 20);

    execute.return_push = 1'b1;
    execute.npc = 32'h0000_0886;
    @(negedge clock);
    execute = '0;
    @(negedge clock);
    decode.pc = 32'h0000_0900;
    decode.return_pop = 1'b1;
    @(negedge clock);
    decode = '0;
    check_target(32'h0000_0886, 1'b1);
    run_sequential(32'h0000_0600, 20);

    seq_on = 1'b0;
    stall = 1'b1;
    @(negedge clock);
    repeat (6) begin
      stall_chk = 1'b1;
      @(negedge clock);
    end
    stall_chk = 1'b0;
    stall = 1'b0;
    repeat (2) @(negedge clock);
    run_sequential(32'h0000_0700, 20);

    if (seq_hits == 0 || instr_hits == 0 || target_hits == 0 || stall_hits == 0) begin
      $display("A check was never reached by the stimulus");
      $display("Test failures found");
      $fatal(1);
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog timeout, the run did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* fetch_unit.f */
rtl/fetch_pkg.sv
rtl/predict_pkg.sv
rtl/branch_predictor.sv
rtl/fetch_buffer.sv
rtl/fetch_stage.sv
rtl/fetch_unit.sv
bench/clock_gen.sv
bench/tb_fetch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch_unit \
  -f fetch_unit.f -o sim_fetch_unit
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_fetch_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
else
  exit 1
fi
